//--- Bender.yml
package:
  name: lc4_core

sources:
  - common/lc4_pkg.sv
  - logic/lc4_fetch_stage.sv
  - logic/lc4_decode_stage.sv
  - logic/lc4_regfile.sv
  - logic/lc4_execute_stage.sv
  - logic/lc4_memory_stage.sv
  - logic/lc4_core.sv
  - target: test
    files:
      - verification/lc4_core_properties.sv
      - verification/tb_lc4_core.sv

//--- common/lc4_pkg.sv
/* widths, opcodes, the two views of an instruction word and the
   payloads passed between the five pipeline stages */
`default_nettype none

package lc4_pkg;

    localparam int XLEN  = 16;
    localparam int NREG  = 8;
    localparam int REG_W = 3;
    localparam logic [XLEN-1:0] RESET_PC = 16'h8200;

    // major opcodes in insn[15:12]
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    localparam logic [2:0] SUB_ADD = 3'b000;  // arith group
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;  // logic group
    localparam logic [2:0] SUB_NOT = 3'b001;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    typedef struct packed {
        logic [3:0]       opcode;
        logic [REG_W-1:0] rd;     // nzp mask for BR, data reg for STR
        logic [REG_W-1:0] rs;
        logic [2:0]       sub;
        logic [REG_W-1:0] rt;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0]       opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs;
        logic             imm_flag; // top bit of imm6 for LDR and STR
        logic [4:0]       imm5;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } insn_u;

    typedef struct packed {
        logic rs_re;
        logic rt_re;
        logic rf_we;
        logic nzp_we;
        logic is_load;
        logic is_store;
        logic is_branch;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        insn_u           insn;
    } fd_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        insn_u           insn;
        ctrl_t           ctrl;
        logic [XLEN-1:0] rs_data;
        logic [XLEN-1:0] rt_data;
    } dx_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        insn_u           insn;
        ctrl_t           ctrl;
        logic [XLEN-1:0] alu_result; // address for loads and stores
        logic [XLEN-1:0] store_data;
    } xm_t;

    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        insn_u            insn;
        logic             rf_we;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  wdata;
        logic             nzp_we;
        logic [2:0]       nzp;
        logic             dmem_we;
        logic [XLEN-1:0]  dmem_addr;
        logic [XLEN-1:0]  dmem_data;
    } retire_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

    // second read register, STR keeps its data register in the rd slot
    function automatic logic [REG_W-1:0] rt_index(input insn_u insn);
        return (insn.r.opcode == OP_STR) ? insn.r.rd : insn.r.rt;
    endfunction

    function automatic logic [2:0] nzp_of(input logic [XLEN-1:0] value);
        if (value == '0)
            return 3'b010;
        return value[XLEN-1] ? 3'b100 : 3'b001;
    endfunction

endpackage

`default_nettype wire

//--- filelist.f
common/lc4_pkg.sv
logic/lc4_fetch_stage.sv
logic/lc4_decode_stage.sv
logic/lc4_regfile.sv
logic/lc4_execute_stage.sv
logic/lc4_memory_stage.sv
logic/lc4_core.sv
verification/lc4_core_properties.sv
verification/tb_lc4_core.sv

//--- logic/lc4_core.sv
/* five-stage LC4 core top, connects the stages, the register file
   and the memory and retire ports */
`timescale 1ns/1ps
`default_nettype none

module lc4_core import lc4_pkg::*; (
    input  logic            gwe,
    input  logic            i_reset,
    output logic [XLEN-1:0] o_imem_addr,
    input  insn_u           i_imem_data,
    output dmem_req_t       o_dmem,
    input  logic [XLEN-1:0] i_dmem_rdata,
    output retire_t         o_retire
);

    fd_t              fd;
    dx_t              dx;
    xm_t              xm;
    redirect_t        redirect;     // from execute on a taken branch
    logic             stall;
    logic [REG_W-1:0] rs_sel;
    logic [REG_W-1:0] rt_sel;
    logic [XLEN-1:0]  rs_data;
    logic [XLEN-1:0]  rt_data;
    logic             ld_nzp_valid;
    logic [2:0]       ld_nzp;

    lc4_fetch_stage u_fetch (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .i_imem_data (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_fd        (fd)
    );

    lc4_decode_stage u_decode (
        .gwe        (gwe),
        .i_reset    (i_reset),
        .i_fd       (fd),
        .i_redirect (redirect),
        .o_rs_sel   (rs_sel),
        .o_rt_sel   (rt_sel),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_stall    (stall),
        .o_dx       (dx)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wb      (o_retire)       // writeback is the retire bundle
    );

    lc4_execute_stage u_execute (
        .gwe            (gwe),
        .i_reset        (i_reset),
        .i_dx           (dx),
        .i_wb           (o_retire),
        .i_ld_nzp_valid (ld_nzp_valid),
        .i_ld_nzp       (ld_nzp),
        .o_redirect     (redirect),
        .o_xm           (xm)
    );

    lc4_memory_stage u_memory (
        .gwe            (gwe),
        .i_reset        (i_reset),
        .i_xm           (xm),
        .o_dmem         (o_dmem),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_ld_nzp_valid (ld_nzp_valid),
        .o_ld_nzp       (ld_nzp),
        .o_wb           (o_retire)
    );

endmodule

`default_nettype wire

//--- logic/lc4_decode_stage.sv
/* decode stage, control decode, register reads, load-to-use detection
   and the decode-to-execute register */
`timescale 1ns/1ps
`default_nettype none

module lc4_decode_stage import lc4_pkg::*; (
    input  logic             gwe,
    input  logic             i_reset,
    input  fd_t              i_fd,
    input  redirect_t        i_redirect,
    output logic [REG_W-1:0] o_rs_sel,
    output logic [REG_W-1:0] o_rt_sel,
    input  logic [XLEN-1:0]  i_rs_data,
    input  logic [XLEN-1:0]  i_rt_data,
    output logic             o_stall,
    output dx_t              o_dx
);

    ctrl_t            ctrl;
    logic [REG_W-1:0] ld_rd;
    logic             uses_ld;
    dx_t              dx_d;

    always_comb begin
        ctrl = '0;
        case (i_fd.insn.r.opcode)
            OP_ARITH, OP_LOGIC: begin
                ctrl.rs_re  = 1'b1;
                // immediate forms and NOT have no second source
                ctrl.rt_re  = !i_fd.insn.i.imm_flag &&
                              !(i_fd.insn.r.opcode == OP_LOGIC &&
                                i_fd.insn.r.sub == SUB_NOT);
                ctrl.rf_we  = 1'b1;
                ctrl.nzp_we = 1'b1;
            end
            OP_LDR: begin
                ctrl.rs_re   = 1'b1;
                ctrl.rf_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                ctrl.rs_re    = 1'b1;
                ctrl.rt_re    = 1'b1;   // data register
                ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                ctrl.rf_we  = 1'b1;
                ctrl.nzp_we = 1'b1;
            end
            OP_BR:   ctrl.is_branch = 1'b1;
            default: ctrl = '0;         // outside the subset, retires as a no-op
        endcase
    end

    assign o_rs_sel = i_fd.insn.r.rs;
    assign o_rt_sel = rt_index(i_fd.insn);

    // load sitting in execute, a branch needs the nzp it produces
    assign ld_rd   = o_dx.insn.r.rd;
    assign uses_ld = (ctrl.rs_re && o_rs_sel == ld_rd) ||
                     (ctrl.rt_re && o_rt_sel == ld_rd) ||
                     ctrl.is_branch;
    assign o_stall = i_fd.valid && o_dx.valid && o_dx.ctrl.is_load && uses_ld;

    always_comb begin
        dx_d.valid   = i_fd.valid && !o_stall && !i_redirect.valid;
        dx_d.pc      = i_fd.pc;
        dx_d.insn    = i_fd.insn;
        dx_d.ctrl    = ctrl;
        dx_d.rs_data = i_rs_data;
        dx_d.rt_data = i_rt_data;
    end

    always_ff @(posedge gwe) begin
        o_dx <= dx_d;
        if (i_reset)
            o_dx.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- logic/lc4_execute_stage.sv
/* execute stage, MX and WX bypass, ALU, NZP register, branch
   resolution and the execute-to-memory register */
`timescale 1ns/1ps
`default_nettype none

module lc4_execute_stage import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_reset,
    input  dx_t       i_dx,
    input  retire_t   i_wb,
    input  logic      i_ld_nzp_valid,
    input  logic [2:0] i_ld_nzp,
    output redirect_t o_redirect,
    output xm_t       o_xm
);

    logic [XLEN-1:0]  rs_val;
    logic [XLEN-1:0]  rt_val;
    logic [XLEN-1:0]  imm5_sx;
    logic [XLEN-1:0]  imm6_sx;
    logic [XLEN-1:0]  imm9_sx;
    logic [XLEN-1:0]  result;
    logic [XLEN-1:0]  br_target;
    logic [2:0]       nzp_q;
    logic             br_taken;
    xm_t              xm_d;
    insn_u            insn;

    // memory stage is younger than writeback, so it is checked first
    function automatic logic [XLEN-1:0] forward(input logic [REG_W-1:0] sel,
                                                input logic [XLEN-1:0]  rf_val,
                                                input xm_t              xm,
                                                input retire_t          wb);
        if (xm.valid && xm.ctrl.rf_we && xm.insn.r.rd == sel)
            return xm.alu_result;
        if (wb.valid && wb.rf_we && wb.rd == sel)
            return wb.wdata;
        return rf_val;
    endfunction

    assign insn   = i_dx.insn;
    assign rs_val = forward(insn.r.rs, i_dx.rs_data, o_xm, i_wb);
    assign rt_val = forward(rt_index(insn), i_dx.rt_data, o_xm, i_wb);

    assign imm5_sx = {{(XLEN-5){insn.i.imm5[4]}}, insn.i.imm5};
    assign imm6_sx = {{(XLEN-6){insn.i.imm_flag}}, insn.i.imm_flag, insn.i.imm5};
    assign imm9_sx = {{(XLEN-9){insn.i.rs[2]}}, insn.i.rs, insn.i.imm_flag, insn.i.imm5};

    always_comb begin
        result = '0;
        case (insn.r.opcode)
            OP_ARITH: begin
                if (insn.i.imm_flag)
                    result = rs_val + imm5_sx;
                else if (insn.r.sub == SUB_SUB)
                    result = rs_val - rt_val;
                else if (insn.r.sub == SUB_ADD)
                    result = rs_val + rt_val;
            end
            OP_LOGIC: begin
                if (insn.i.imm_flag) begin
                    result = rs_val & imm5_sx;
                end else begin
                    case (insn.r.sub)
                        SUB_AND: result = rs_val & rt_val;
                        SUB_NOT: result = ~rs_val;
                        SUB_OR:  result = rs_val | rt_val;
                        SUB_XOR: result = rs_val ^ rt_val;
                        default: result = '0;
                    endcase
                end
            end
            OP_LDR, OP_STR: result = rs_val + imm6_sx;   // effective address
            OP_CONST:       result = imm9_sx;
            default:        result = '0;
        endcase
    end

    // predicted not taken, a hit squashes fetch and decode
    assign br_target = i_dx.pc + 1'b1 + imm9_sx;
    assign br_taken  = i_dx.valid && i_dx.ctrl.is_branch && |(nzp_q & insn.r.rd);

    always_comb begin
        o_redirect.valid  = br_taken;
        o_redirect.target = br_target;
    end

    always_ff @(posedge gwe) begin
        if (i_reset)
            nzp_q <= '0;
        else if (i_dx.valid && i_dx.ctrl.nzp_we && !i_dx.ctrl.is_load)
            nzp_q <= nzp_of(result);
        else if (i_ld_nzp_valid)
            nzp_q <= i_ld_nzp;      // older load, only when execute leaves nzp alone
    end

    always_comb begin
        xm_d.valid      = i_dx.valid;
        xm_d.pc         = i_dx.pc;
        xm_d.insn       = insn;
        xm_d.ctrl       = i_dx.ctrl;
        xm_d.alu_result = result;
        xm_d.store_data = rt_val;
    end

    always_ff @(posedge gwe) begin
        o_xm <= xm_d;
        if (i_reset)
            o_xm.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- logic/lc4_fetch_stage.sv
/* fetch stage, PC register, next-PC choice and the fetch-to-decode
   register with stall hold and redirect squash */
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch_stage import lc4_pkg::*; (
    input  logic            gwe,
    input  logic            i_reset,
    input  logic            i_stall,
    input  redirect_t       i_redirect,
    input  insn_u           i_imem_data,
    output logic [XLEN-1:0] o_imem_addr,
    output fd_t             o_fd
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    fd_t             fd_d;

    assign o_imem_addr = pc_q;  // memory answers in the same cycle

    always_comb begin
        pc_d       = pc_q + 1'b1;
        fd_d.valid = 1'b1;
        fd_d.pc    = pc_q;
        fd_d.insn  = i_imem_data;
        if (i_redirect.valid) begin
            // taken branch in execute, drop the word fetched this cycle
            pc_d       = i_redirect.target;
            fd_d.valid = 1'b0;
        end else if (i_stall) begin
            pc_d = pc_q;
            fd_d = o_fd;            // hold for the load-to-use bubble
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset)
            pc_q <= RESET_PC;
        else
            pc_q <= pc_d;
    end

    always_ff @(posedge gwe) begin
        o_fd <= fd_d;
        if (i_reset)
            o_fd.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- logic/lc4_memory_stage.sv
/* memory stage, data memory request with WM store bypass, load
   result select and the writeback register */
`timescale 1ns/1ps
`default_nettype none

module lc4_memory_stage import lc4_pkg::*; (
    input  logic            gwe,
    input  logic            i_reset,
    input  xm_t             i_xm,
    output dmem_req_t       o_dmem,
    input  logic [XLEN-1:0] i_dmem_rdata,
    output logic            o_ld_nzp_valid,
    output logic [2:0]      o_ld_nzp,
    output retire_t         o_wb
);

    logic [XLEN-1:0] st_data;
    logic [XLEN-1:0] wb_val;
    logic            wm_hit;
    logic            is_mem;
    retire_t         wb_d;

    // STR data register sits in the rd slot
    assign wm_hit  = i_xm.ctrl.is_store && o_wb.valid && o_wb.rf_we &&
                     o_wb.rd == i_xm.insn.r.rd;
    assign st_data = wm_hit ? o_wb.wdata : i_xm.store_data;
    assign is_mem  = i_xm.ctrl.is_load || i_xm.ctrl.is_store;

    always_comb begin
        o_dmem.we    = i_xm.valid && i_xm.ctrl.is_store;
        o_dmem.addr  = i_xm.alu_result;
        o_dmem.wdata = st_data;
    end

    assign wb_val         = i_xm.ctrl.is_load ? i_dmem_rdata : i_xm.alu_result;
    assign o_ld_nzp_valid = i_xm.valid && i_xm.ctrl.is_load;
    assign o_ld_nzp       = nzp_of(i_dmem_rdata);

    always_comb begin
        wb_d.valid     = i_xm.valid;
        wb_d.pc        = i_xm.pc;
        wb_d.insn      = i_xm.insn;
        wb_d.rf_we     = i_xm.ctrl.rf_we;
        wb_d.rd        = i_xm.insn.r.rd;
        wb_d.wdata     = wb_val;
        wb_d.nzp_we    = i_xm.ctrl.nzp_we;
        wb_d.nzp       = nzp_of(wb_val);
        wb_d.dmem_we   = i_xm.ctrl.is_store;
        wb_d.dmem_addr = is_mem ? i_xm.alu_result : '0;
        wb_d.dmem_data = i_xm.ctrl.is_load  ? i_dmem_rdata :
                         i_xm.ctrl.is_store ? st_data : '0;
    end

    always_ff @(posedge gwe) begin
        o_wb <= wb_d;
        if (i_reset)
            o_wb.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- logic/lc4_regfile.sv
/* eight-entry register file, two read ports with write-through
   and one write port fed from writeback */
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
    input  logic             gwe,
    input  logic             i_reset,
    input  logic [REG_W-1:0] i_rs_sel,
    input  logic [REG_W-1:0] i_rt_sel,
    output logic [XLEN-1:0]  o_rs_data,
    output logic [XLEN-1:0]  o_rt_data,
    input  retire_t          i_wb
);

    logic [XLEN-1:0] regs [NREG];
    logic            wr_en;

    assign wr_en = i_wb.valid && i_wb.rf_we;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int k = 0; k < NREG; k++)
                regs[k] <= '0;
        end else if (wr_en) begin
            regs[i_wb.rd] <= i_wb.wdata;
        end
    end

    // same-cycle write is visible to decode
    assign o_rs_data = (wr_en && i_wb.rd == i_rs_sel) ? i_wb.wdata : regs[i_rs_sel];
    assign o_rt_data = (wr_en && i_wb.rd == i_rt_sel) ? i_wb.wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- verification/lc4_core_properties.sv
/* concurrent checks on the memory port, the retire port and the
   reset state of lc4_core */
`timescale 1ns/1ps
`default_nettype none

module lc4_core_properties import lc4_pkg::*; (
    input logic            gwe,
    input logic            i_reset,
    input logic [XLEN-1:0] i_imem_addr,
    input xm_t             i_xm,
    input dmem_req_t       i_dmem,
    input retire_t         i_retire
);

    // stores come only from a valid memory-stage entry
    a_store_needs_valid: assert property (@(posedge gwe) disable iff (i_reset)
        i_dmem.we |-> i_xm.valid)
        else $error("data memory write with no valid instruction in the memory stage");

    a_quiet_after_reset: assert property (@(posedge gwe) i_reset |=> !i_retire.valid)
        else $error("retire valid in the cycle after reset");

    a_reset_vector: assert property (@(posedge gwe) i_reset |=> i_imem_addr == RESET_PC)
        else $error("fetch address is not the reset vector after reset");

endmodule

`default_nettype wire

//--- verification/tb_lc4_core.sv
/* testbench for the LC4 core with instruction and data memory models,
   a program table of expected retire entries and the final report */
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_core import lc4_pkg::*; ();

    localparam int NPROG          = 32;
    localparam int RETIRE_TIMEOUT = 40;
    localparam int DMEM_WORDS     = 65536;

    typedef struct packed {
        logic [15:0] insn;
        logic        retires;   // low for the two slots behind a taken branch
        logic        rf_we;
        logic [2:0]  rd;
        logic [15:0] value;
        logic        dmem_we;
        logic [15:0] addr;
        logic [15:0] data;
    } step_t;

    logic            gwe;
    logic            i_reset;
    logic [XLEN-1:0] o_imem_addr;
    insn_u           i_imem_data;
    dmem_req_t       o_dmem;
    logic [XLEN-1:0] i_dmem_rdata;
    retire_t         o_retire;

    step_t       prog [NPROG];
    logic [15:0] dmem [DMEM_WORDS];
    int          error_count;
    int          check_count;

    lc4_core u_dut (
        .gwe          (gwe),
        .i_reset      (i_reset),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem       (o_dmem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_retire     (o_retire)
    );

    bind lc4_core lc4_core_properties u_props (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_imem_addr (o_imem_addr),
        .i_xm        (xm),
        .i_dmem      (o_dmem),
        .i_retire    (o_retire)
    );

    always #4 gwe = ~gwe;   // 8 ns period

    function automatic logic [15:0] alu_rr(input logic [3:0] op, input logic [2:0] sub,
                                           input logic [2:0] d, s, t);
        return {op, d, s, sub, t};
    endfunction

    function automatic logic [15:0] alu_ri(input logic [3:0] op, input logic [2:0] d, s,
                                           input logic [4:0] imm);
        return {op, d, s, 1'b1, imm};
    endfunction

    // LDR and STR share one layout with the STR data register in the rd slot
    function automatic logic [15:0] mem_op(input logic [3:0] op, input logic [2:0] r, base,
                                           input logic [5:0] off);
        return {op, r, base, off};
    endfunction

    function automatic logic [15:0] const_i(input logic [2:0] d, input logic [8:0] imm);
        return {OP_CONST, d, imm};
    endfunction

    function automatic logic [15:0] branch_on(input logic [2:0] nzp, input logic [8:0] off);
        return {OP_BR, nzp, off};
    endfunction

    // sign class of a written value as the ISA defines it
    function automatic logic [2:0] expected_nzp(input logic [15:0] value);
        if ($signed(value) < 0)
            return 3'b100;
        if (value == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        logic [15:0] off;
        off = addr - RESET_PC;
        if (off < 16'(NPROG))
            return prog[off].insn;
        return 16'h0000;            // NOP past the end of the program
    endfunction

    task automatic write_entry(input int idx, input logic [15:0] insn,
                               input logic [2:0] rd, input logic [15:0] value);
        prog[idx]         = '0;
        prog[idx].insn    = insn;
        prog[idx].retires = 1'b1;
        prog[idx].rf_we   = 1'b1;
        prog[idx].rd      = rd;
        prog[idx].value   = value;
    endtask

    task automatic store_entry(input int idx, input logic [15:0] insn,
                               input logic [15:0] addr, input logic [15:0] data);
        prog[idx]         = '0;
        prog[idx].insn    = insn;
        prog[idx].retires = 1'b1;
        prog[idx].dmem_we = 1'b1;
        prog[idx].addr    = addr;
        prog[idx].data    = data;
    endtask

    task automatic plain_entry(input int idx, input logic [15:0] insn, input logic retires);
        prog[idx]         = '0;
        prog[idx].insn    = insn;
        prog[idx].retires = retires;
    endtask

    task automatic build_program();
        logic [15:0] v10;
        v10 = dmem[10];
        // dependent ALU chain where operands arrive through MX and WX
        write_entry(0,  const_i(3'd1, 9'h007), 3'd1, 16'h0007);
        write_entry(1,  const_i(3'd2, 9'h1fd), 3'd2, 16'hfffd);
        write_entry(2,  alu_rr(OP_ARITH, SUB_ADD, 3'd3, 3'd1, 3'd2), 3'd3, 16'h0004);
        write_entry(3,  alu_rr(OP_ARITH, SUB_SUB, 3'd4, 3'd3, 3'd1), 3'd4, 16'hfffd);
        write_entry(4,  alu_rr(OP_LOGIC, SUB_AND, 3'd5, 3'd4, 3'd1), 3'd5, 16'h0005);
        write_entry(5,  alu_rr(OP_LOGIC, SUB_OR,  3'd6, 3'd5, 3'd2), 3'd6, 16'hfffd);
        write_entry(6,  alu_rr(OP_LOGIC, SUB_XOR, 3'd7, 3'd6, 3'd3), 3'd7, 16'hfff9);
        write_entry(7,  alu_rr(OP_LOGIC, SUB_NOT, 3'd1, 3'd7, 3'd0), 3'd1, 16'h0006);
        write_entry(8,  alu_ri(OP_ARITH, 3'd2, 3'd1, 5'h1e), 3'd2, 16'h0004);
        write_entry(9,  alu_ri(OP_LOGIC, 3'd3, 3'd7, 5'h0d), 3'd3, 16'h0009);
        // load-to-use stall then a store of the value made just before
        write_entry(10, mem_op(OP_LDR, 3'd4, 3'd0, 6'd10), 3'd4, v10);
        write_entry(11, alu_rr(OP_ARITH, SUB_ADD, 3'd5, 3'd4, 3'd3), 3'd5, v10 + 16'h0009);
        write_entry(12, alu_ri(OP_ARITH, 3'd6, 3'd5, 5'h01), 3'd6, v10 + 16'h000a);
        store_entry(13, mem_op(OP_STR, 3'd6, 3'd0, 6'd20), 16'h0014, v10 + 16'h000a);
        write_entry(14, mem_op(OP_LDR, 3'd7, 3'd0, 6'd20), 3'd7, v10 + 16'h000a);
        // a branch right after a load of zero has to see z
        write_entry(15, const_i(3'd1, 9'h000), 3'd1, 16'h0000);
        store_entry(16, mem_op(OP_STR, 3'd1, 3'd0, 6'd21), 16'h0015, 16'h0000);
        write_entry(17, const_i(3'd2, 9'h005), 3'd2, 16'h0005);
        write_entry(18, mem_op(OP_LDR, 3'd3, 3'd0, 6'd21), 3'd3, 16'h0000);
        plain_entry(19, branch_on(3'b010, 9'h002), 1'b1);   // BRz taken
        plain_entry(20, const_i(3'd4, 9'h001), 1'b0);
        plain_entry(21, const_i(3'd4, 9'h002), 1'b0);
        plain_entry(22, branch_on(3'b100, 9'h003), 1'b1);   // BRn falls through
        plain_entry(23, 16'h0000, 1'b1);                     // NOP
        write_entry(24, const_i(3'd5, 9'h1ff), 3'd5, 16'hffff);
        plain_entry(25, branch_on(3'b100, 9'h002), 1'b1);   // BRn taken
        plain_entry(26, const_i(3'd6, 9'h003), 1'b0);
        plain_entry(27, const_i(3'd6, 9'h004), 1'b0);
        write_entry(28, alu_rr(OP_ARITH, SUB_ADD, 3'd7, 3'd5, 3'd5), 3'd7, 16'hfffe);
        plain_entry(29, branch_on(3'b011, 9'h002), 1'b1);   // BRzp not taken
        write_entry(30, alu_ri(OP_ARITH, 3'd1, 3'd7, 5'h05), 3'd1, 16'h0003);
        plain_entry(31, 16'h0000, 1'b1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // quiet also demands that no store reaches memory while waiting
    task automatic next_retire(input logic quiet, output logic found);
        found = 1'b0;
        for (int n = 0; n < RETIRE_TIMEOUT && !found; n++) begin
            @(negedge gwe);
            if (quiet)
                check_value("o_dmem.we", 16'(o_dmem.we), 16'h0000);
            found = o_retire.valid;
        end
    endtask

    task automatic check_retire(input int idx);
        step_t e;
        e = prog[idx];
        check_value("o_retire.pc", o_retire.pc, RESET_PC + 16'(idx));
        check_value("o_retire.insn", o_retire.insn, e.insn);
        check_value("o_retire.rf_we", 16'(o_retire.rf_we), 16'(e.rf_we));
        // every register write in this subset also sets the condition codes
        check_value("o_retire.nzp_we", 16'(o_retire.nzp_we), 16'(e.rf_we));
        if (e.rf_we) begin
            check_value("o_retire.rd", 16'(o_retire.rd), 16'(e.rd));
            check_value("o_retire.wdata", o_retire.wdata, e.value);
            check_value("o_retire.nzp", 16'(o_retire.nzp), 16'(expected_nzp(e.value)));
        end
        check_value("o_retire.dmem_we", 16'(o_retire.dmem_we), 16'(e.dmem_we));
        if (e.dmem_we) begin
            check_value("o_retire.dmem_addr", o_retire.dmem_addr, e.addr);
            check_value("o_retire.dmem_data", o_retire.dmem_data, e.data);
        end
    endtask

    // both memories answer within the cycle and are refreshed on the falling edge
    always @(negedge gwe) begin
        if (o_dmem.we === 1'b1)
            dmem[o_dmem.addr] = o_dmem.wdata;
        i_dmem_rdata = dmem[o_dmem.addr];
        i_imem_data  = fetch_word(o_imem_addr);
    end

    initial begin
        logic found;
        gwe          = 1'b0;
        i_reset      = 1'b1;
        i_imem_data  = '0;
        i_dmem_rdata = '0;
        error_count  = 0;
        check_count  = 0;
        void'($urandom(11));
        for (int a = 0; a < DMEM_WORDS; a++)
            dmem[a] = 16'($urandom());
        build_program();

        repeat (16) @(negedge gwe);
        check_value("o_imem_addr", o_imem_addr, RESET_PC);     // reset vector
        check_value("o_retire.valid", 16'(o_retire.valid), 16'h0000);
        check_value("o_dmem.we", 16'(o_dmem.we), 16'h0000);
        i_reset = 1'b0;

        for (int i = 0; i < NPROG; i++) begin
            if (!prog[i].retires)
                continue;
            next_retire(i == 0, found);
            if (!found) begin
                error_count++;
                $display("timeout: instruction at pc 0x%h did not retire within %0d cycles",
                         RESET_PC + 16'(i), RETIRE_TIMEOUT);
                break;
            end
            check_retire(i);
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
